// File: shader_macros.svh
`ifndef SHADER_MACROS_SVH
`define SHADER_MACROS_SVH

// ############################################################
// Shader subsystem widths and depths
// ############################################################

`define SHADER_WORD_WIDTH      32  // Data and instruction word
`define SHADER_ADDR_WIDTH      16  // Byte address
`define SHADER_RAM_WORDS_LOG2  10  // 1024 words per RAM
`define SHADER_REG_COUNT_LOG2  4   // 16 registers

`endif

// File: shader_pkg.sv
`default_nettype none

`include "shader_macros.svh"

package shader_pkg;

    typedef logic [`SHADER_WORD_WIDTH-1:0]     word_t;
    typedef logic [`SHADER_ADDR_WIDTH-1:0]     byte_addr_t;
    typedef logic [`SHADER_RAM_WORDS_LOG2-1:0] word_index_t;
    typedef logic [`SHADER_REG_COUNT_LOG2-1:0] reg_index_t;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        LOADI = 4'd1,
        ADD   = 4'd2,
        SUB   = 4'd3,
        MUL   = 4'd4,
        LOAD  = 4'd5,
        STORE = 4'd6,
        BNZ   = 4'd7,
        HALT  = 4'd15
    } opcode_e;

    // Instruction word layout
    typedef struct packed {
        opcode_e     opcode;  // 31:28
        reg_index_t  rd;      // 27:24
        reg_index_t  ra;      // 23:20
        reg_index_t  rb;      // 19:16
        logic [15:0] imm;     // 15:0
    } instruction_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM_WAIT,
        WRITEBACK,
        HALTED
    } core_state_e;

    // One RAM port access
    typedef struct packed {
        byte_addr_t addr;
        logic       write;
        word_t      wdata;
    } mem_req_t;

    // Host load, to_data selects the data RAM
    typedef struct packed {
        logic       to_data;
        byte_addr_t addr;
        word_t      data;
    } load_req_t;

endpackage

`default_nettype wire

// File: block_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "shader_macros.svh"

module block_ram import shader_pkg::*; (
    input  logic     clock,
    input  mem_req_t port,
    output word_t    read_data
);

    word_t       mem [0:(1 << `SHADER_RAM_WORDS_LOG2)-1];
    word_index_t index;

    // Byte address bits 11:2 pick the word
    assign index = port.addr[`SHADER_RAM_WORDS_LOG2+1:2];

    always_ff @(posedge clock) begin
        if (port.write) begin
            mem[index] <= port.wdata;
        end
        read_data <= mem[index];  // Old word on a write cycle
    end

endmodule

`default_nettype wire

// File: program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader import shader_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      run,
    input  logic      load_valid,
    output logic      load_ready,
    input  load_req_t load_req,
    output mem_req_t  load_mem,
    output logic      load_to_data
);

    logic      accept;
    logic      write_q;   // Write pending toward the RAMs
    load_req_t held;      // Last accepted host write

    // One write per cycle, so only run can hold the host off
    assign load_ready = !run;
    assign accept     = load_valid && load_ready;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_q <= 1'b0;
        end else begin
            write_q <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held <= load_req;
        end
    end

    assign load_mem     = '{addr: held.addr, write: write_q, wdata: held.data};
    assign load_to_data = held.to_data;

    // Host must finish loading before the program starts
    a_no_load_while_running: assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(load_valid) |-> !run
    ) else $error("load_valid rose while run is high");

endmodule

`default_nettype wire

// File: memory_port_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "shader_macros.svh"

module memory_port_select import shader_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       run,
    input  logic       halted,
    input  mem_req_t   load_mem,
    input  logic       load_to_data,
    input  byte_addr_t fetch_addr,
    input  mem_req_t   core_data_req,
    input  byte_addr_t reader_addr,
    output mem_req_t   inst_port,
    output mem_req_t   data_port
);

    logic load_inst_write;
    logic load_data_write;

    // Keep only the word index bits, word aligned
    function automatic byte_addr_t word_align(input byte_addr_t addr);
        byte_addr_t aligned;
        aligned = '0;
        aligned[`SHADER_RAM_WORDS_LOG2+1:2] = addr[`SHADER_RAM_WORDS_LOG2+1:2];
        return aligned;
    endfunction

    assign load_inst_write = load_mem.write && !load_to_data;
    assign load_data_write = load_mem.write && load_to_data;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            inst_port.write <= 1'b0;
            data_port.write <= 1'b0;
        end else if (!run) begin
            // Host side owns both RAMs
            inst_port <= '{addr: word_align(load_mem.addr), write: load_inst_write,
                           wdata: load_mem.wdata};
            if (load_data_write) begin
                data_port <= '{addr: word_align(load_mem.addr), write: 1'b1,
                               wdata: load_mem.wdata};
            end else begin
                data_port <= '{addr: word_align(reader_addr), write: 1'b0,
                               wdata: load_mem.wdata};
            end
        end else begin
            inst_port <= '{addr: word_align(fetch_addr), write: 1'b0, wdata: '0};
            if (halted) begin
                data_port <= '{addr: word_align(reader_addr), write: 1'b0, wdata: '0};
            end else begin
                data_port <= '{addr: word_align(core_data_req.addr),
                               write: core_data_req.write,
                               wdata: core_data_req.wdata};
            end
        end
    end

    // A loader write still in flight when run rises would never reach a RAM
    a_no_load_write_while_running: assert property (
        @(posedge clock) disable iff (!reset_n)
        load_mem.write |-> !run
    ) else $error("Loader write dropped because run is high");

endmodule

`default_nettype wire

// File: shader_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "shader_macros.svh"

module shader_core import shader_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       run,
    output logic       halted,
    output byte_addr_t fetch_addr,
    input  word_t      inst_word,
    output mem_req_t   core_data_req,
    input  word_t      data_word
);

    localparam int PC_WIDTH = `SHADER_RAM_WORDS_LOG2 + 2;

    core_state_e         state;
    logic [PC_WIDTH-1:0] pc;           // Byte address within the RAM
    logic [PC_WIDTH-1:0] pc_plus4;
    logic [PC_WIDTH-1:0] next_pc;
    logic                wait_count;   // Second FETCH_WAIT cycle when set
    instruction_t        ir;

    word_t rf [0:(1 << `SHADER_REG_COUNT_LOG2)-1];
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    logic  alu_writes;

    assign fetch_addr = byte_addr_t'(pc);
    assign op_a       = rf[ir.ra];
    assign op_b       = rf[ir.rb];
    assign pc_plus4   = pc + PC_WIDTH'(4);

    // ############################################################
    // ALU and branch
    // ############################################################

    always_comb begin
        alu_result = '0;
        alu_writes = 1'b0;
        case (ir.opcode)
            LOADI: begin
                alu_result = word_t'(ir.imm);  // Zero extended
                alu_writes = 1'b1;
            end
            ADD: begin
                alu_result = op_a + op_b;
                alu_writes = 1'b1;
            end
            SUB: begin
                alu_result = op_a - op_b;
                alu_writes = 1'b1;
            end
            MUL: begin
                alu_result = op_a * op_b;  // Low half only
                alu_writes = 1'b1;
            end
            default: begin
                alu_writes = 1'b0;  // NOP, memory, branch, unknown
            end
        endcase
    end

    always_comb begin
        if (ir.opcode == BNZ && op_a != '0) begin
            next_pc = ir.imm[PC_WIDTH-1:0];
        end else begin
            next_pc = pc_plus4;
        end
    end

    // LOAD and STORE address is ra plus imm
    assign core_data_req.addr  = op_a[`SHADER_ADDR_WIDTH-1:0] + ir.imm;
    assign core_data_req.write = (state == EXECUTE) && (ir.opcode == STORE);
    assign core_data_req.wdata = op_b;

    // ############################################################
    // Control state machine
    // ############################################################

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= IDLE;
            halted     <= 1'b0;
            pc         <= '0;
            wait_count <= 1'b0;
        end else if (!run) begin
            state  <= IDLE;  // Also leaves HALTED
            halted <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    pc    <= '0;
                    state <= FETCH;
                end
                FETCH: begin
                    wait_count <= 1'b0;
                    state      <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    wait_count <= 1'b1;
                    if (wait_count) begin
                        state <= EXECUTE;  // inst_word is valid now
                    end
                end
                EXECUTE: begin
                    pc <= next_pc;
                    case (ir.opcode)
                        LOAD: state <= MEM_WAIT;
                        HALT: begin
                            state  <= HALTED;
                            halted <= 1'b1;
                        end
                        default: state <= FETCH;
                    endcase
                end
                MEM_WAIT:  state <= WRITEBACK;
                WRITEBACK: state <= FETCH;
                HALTED:    state <= HALTED;  // Until run falls
                default:   state <= IDLE;
            endcase
        end
    end

    // Instruction register and register file
    always_ff @(posedge clock) begin
        if (state == FETCH_WAIT && wait_count) begin
            ir <= instruction_t'(inst_word);
        end
        if (state == EXECUTE && alu_writes) begin
            rf[ir.rd] <= alu_result;
        end else if (state == WRITEBACK) begin
            rf[ir.rd] <= data_word;  // LOAD result
        end
    end

    // A store issued after run falls never reaches the data RAM
    a_store_while_running: assert property (
        @(posedge clock) disable iff (!reset_n)
        core_data_req.write |-> run
    ) else $error("Store issued while run is low");

endmodule

`default_nettype wire

// File: result_reader.sv
`timescale 1ns/1ps
`default_nettype none

module result_reader import shader_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       read_valid,
    output logic       read_ready,
    input  byte_addr_t read_addr,
    input  logic       run,
    input  logic       halted,
    output byte_addr_t reader_addr,
    input  word_t      data_word,
    output logic       resp_valid,
    input  logic       resp_ready,
    output word_t      resp_data
);

    localparam logic [1:0] RAM_LATENCY = 2'd2;  // Select register, then RAM

    logic       pending;     // Read in flight through the RAM path
    logic [1:0] wait_count;
    logic       accept;
    logic       capture;

    // Data RAM is free when the core is stopped or done
    assign read_ready = (!run || halted) && !pending && !resp_valid;
    assign accept     = read_valid && read_ready;
    assign capture    = pending && (wait_count == '0);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pending    <= 1'b0;
            wait_count <= '0;
            resp_valid <= 1'b0;
        end else begin
            if (accept) begin
                pending    <= 1'b1;
                wait_count <= RAM_LATENCY;
            end else if (capture) begin
                pending    <= 1'b0;
                resp_valid <= 1'b1;
            end else if (pending) begin
                wait_count <= wait_count - 2'd1;
            end
            if (resp_valid && resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            reader_addr <= read_addr;
        end
        if (capture) begin
            resp_data <= data_word;  // Held under back-pressure
        end
    end

endmodule

`default_nettype wire

// File: shader_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module shader_subsystem import shader_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       run,
    output logic       halted,
    input  logic       load_valid,
    output logic       load_ready,
    input  load_req_t  load_req,
    input  logic       read_valid,
    output logic       read_ready,
    input  byte_addr_t read_addr,
    output logic       resp_valid,
    input  logic       resp_ready,
    output word_t      resp_data
);

    mem_req_t   load_mem;
    logic       load_to_data;
    byte_addr_t fetch_addr;
    mem_req_t   core_data_req;
    byte_addr_t reader_addr;
    mem_req_t   inst_port;
    mem_req_t   data_port;
    word_t      inst_word;
    word_t      data_word;

    // Host input side
    program_loader i_loader (
        .clock, .reset_n, .run, .load_valid, .load_ready, .load_req,
        .load_mem, .load_to_data
    );

    memory_port_select i_select (
        .clock, .reset_n, .run, .halted, .load_mem, .load_to_data,
        .fetch_addr, .core_data_req, .reader_addr, .inst_port, .data_port
    );

    block_ram i_inst_ram (.clock, .port(inst_port), .read_data(inst_word));
    block_ram i_data_ram (.clock, .port(data_port), .read_data(data_word));

    shader_core i_core (
        .clock, .reset_n, .run, .halted, .fetch_addr, .inst_word,
        .core_data_req, .data_word
    );

    // Host output side
    result_reader i_reader (
        .clock, .reset_n, .read_valid, .read_ready, .read_addr, .run, .halted,
        .reader_addr, .data_word, .resp_valid, .resp_ready, .resp_data
    );

endmodule

`default_nettype wire

// File: tb_shader_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shader_subsystem import shader_pkg::*; ();

    localparam int NUM_TESTS      = 6;
    localparam int MAX_WORDS      = 16;   // Program words per test
    localparam int MAX_ITEMS      = 4;    // Data words and results per test
    localparam int TIMEOUT_CYCLES = 5000;

    logic       clock;
    logic       reset_n;
    logic       run;
    logic       halted;
    logic       load_valid;
    logic       load_ready;
    load_req_t  load_req;
    logic       read_valid;
    logic       read_ready;
    byte_addr_t read_addr;
    logic       resp_valid;
    logic       resp_ready;
    word_t      resp_data;

    // ############################################################
    // Test table
    // ############################################################

    word_t      prog      [NUM_TESTS][MAX_WORDS];
    byte_addr_t data_addr [NUM_TESTS][MAX_ITEMS];
    word_t      data_val  [NUM_TESTS][MAX_ITEMS];
    byte_addr_t res_addr  [NUM_TESTS][MAX_ITEMS];
    word_t      res_val   [NUM_TESTS][MAX_ITEMS];
    int         prog_len  [NUM_TESTS];
    int         data_len  [NUM_TESTS];
    int         res_len   [NUM_TESTS];
    logic       stall     [NUM_TESTS];  // Random resp_ready during readback

    int test_errors;
    int pass_count;
    int fail_count;

    shader_subsystem i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic word_t encode_instr(opcode_e op, int rd, int ra, int rb, int imm);
        return {op, rd[3:0], ra[3:0], rb[3:0], imm[15:0]};
    endfunction

    // RAM word behind a byte address, bits 11:2
    function automatic byte_addr_t word_byte_addr(byte_addr_t addr);
        return {4'b0000, addr[11:2], 2'b00};
    endfunction

    task automatic add_instr(int t, word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_data(int t, byte_addr_t addr, word_t val);
        data_addr[t][data_len[t]] = addr;
        data_val[t][data_len[t]]  = val;
        data_len[t]++;
    endtask

    task automatic add_result(int t, byte_addr_t addr, word_t val);
        res_addr[t][res_len[t]] = word_byte_addr(addr);
        res_val[t][res_len[t]]  = val;
        res_len[t]++;
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        word_t sum;
        int    n;
        int    v;
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            data_len[t] = 0;
            res_len[t]  = 0;
        end
        // Immediates, zero extension and byte to word mapping
        add_instr(0, encode_instr(LOADI, 0, 0, 0, 0));
        add_instr(0, encode_instr(LOADI, 1, 0, 0, 'hBEEF));
        add_instr(0, encode_instr(LOADI, 2, 0, 0, 'h8001));
        add_instr(0, encode_instr(STORE, 0, 0, 1, 'h0100));
        add_instr(0, encode_instr(STORE, 0, 0, 2, 'h0107));  // Unaligned
        add_instr(0, encode_instr(STORE, 0, 0, 1, 'h1108));  // Above bit 11
        add_instr(0, encode_instr(HALT, 0, 0, 0, 0));
        add_result(0, 16'h0100, 32'h0000_BEEF);
        add_result(0, 16'h0107, 32'h0000_8001);
        add_result(0, 16'h1108, 32'h0000_BEEF);
        stall[0] = 1'b0;
        // Wrapping arithmetic near 2^32
        a = $urandom | 32'hFFF0_0000;
        b = $urandom | 32'hFFFF_0000;
        add_data(1, 16'h0200, a);
        add_data(1, 16'h0204, b);
        add_instr(1, encode_instr(LOADI, 0, 0, 0, 0));
        add_instr(1, encode_instr(LOAD, 1, 0, 0, 'h0200));
        add_instr(1, encode_instr(LOAD, 2, 0, 0, 'h0204));
        add_instr(1, encode_instr(ADD, 3, 1, 2, 0));
        add_instr(1, encode_instr(SUB, 4, 1, 2, 0));
        add_instr(1, encode_instr(MUL, 5, 1, 2, 0));
        add_instr(1, encode_instr(STORE, 0, 0, 3, 'h0210));
        add_instr(1, encode_instr(STORE, 0, 0, 4, 'h0214));
        add_instr(1, encode_instr(STORE, 0, 0, 5, 'h0218));
        add_instr(1, encode_instr(HALT, 0, 0, 0, 0));
        add_result(1, 16'h0210, a + b);
        add_result(1, 16'h0214, a - b);
        add_result(1, 16'h0218, a * b);
        stall[1] = 1'b0;
        // Sum of four preloaded words
        sum = '0;
        add_instr(2, encode_instr(LOADI, 0, 0, 0, 0));
        for (int i = 0; i < 4; i++) begin
            a = $urandom;
            sum = sum + a;
            add_data(2, byte_addr_t'('h0300 + 4 * i), a);
            add_instr(2, encode_instr(LOAD, i + 1, 0, 0, 'h0300 + 4 * i));
        end
        add_instr(2, encode_instr(ADD, 5, 1, 2, 0));
        add_instr(2, encode_instr(ADD, 5, 5, 3, 0));
        add_instr(2, encode_instr(ADD, 5, 5, 4, 0));
        add_instr(2, encode_instr(STORE, 0, 0, 5, 'h0320));
        add_instr(2, encode_instr(LOADI, 6, 0, 0, 'h0300));
        add_instr(2, encode_instr(STORE, 0, 6, 5, 'h0024));  // Base register
        add_instr(2, encode_instr(HALT, 0, 0, 0, 0));
        add_result(2, 16'h0320, sum);
        add_result(2, 16'h0324, sum);
        stall[2] = 1'b1;
        // Count down loop summing 1 to n
        n = 10 + int'($urandom % 20);
        add_instr(3, encode_instr(LOADI, 1, 0, 0, n));    // Counter
        add_instr(3, encode_instr(LOADI, 2, 0, 0, 0));    // Running sum
        add_instr(3, encode_instr(LOADI, 3, 0, 0, 1));
        add_instr(3, encode_instr(LOADI, 0, 0, 0, 0));
        add_instr(3, encode_instr(ADD, 2, 2, 1, 0));      // Loop head, byte 16
        add_instr(3, encode_instr(SUB, 1, 1, 3, 0));
        add_instr(3, encode_instr(BNZ, 0, 1, 0, 16));
        add_instr(3, encode_instr(STORE, 0, 0, 2, 'h0400));
        add_instr(3, encode_instr(HALT, 0, 0, 0, 0));
        add_result(3, 16'h0400, word_t'(n * (n + 1) / 2));
        stall[3] = 1'b0;
        // Several results read back under stalls
        add_instr(4, encode_instr(LOADI, 0, 0, 0, 0));
        for (int i = 1; i <= 4; i++) begin
            v = int'($urandom % 65536);
            add_instr(4, encode_instr(LOADI, i, 0, 0, v));
            add_instr(4, encode_instr(STORE, 0, 0, i, 'h0500 + 4 * i));
            add_result(4, byte_addr_t'('h0500 + 4 * i), word_t'(v));
        end
        add_instr(4, encode_instr(HALT, 0, 0, 0, 0));
        stall[4] = 1'b1;
        // Second short program over the previous one
        add_instr(5, encode_instr(LOADI, 0, 0, 0, 0));
        add_instr(5, encode_instr(LOADI, 1, 0, 0, 'h1234));
        add_instr(5, encode_instr(LOADI, 2, 0, 0, 'h0010));
        add_instr(5, encode_instr(MUL, 3, 1, 2, 0));
        add_instr(5, encode_instr(STORE, 0, 0, 3, 'h0100));
        add_instr(5, encode_instr(HALT, 0, 0, 0, 0));
        add_result(5, 16'h0100, 32'h1234 * 32'h10);
        stall[5] = 1'b1;
    endtask

    // ############################################################
    // Host side tasks
    // ############################################################

    task automatic load_word(logic to_data, byte_addr_t addr, word_t data);
        int cycles;
        cycles = 0;
        @(posedge clock);
        load_valid <= 1'b1;
        load_req   <= '{to_data: to_data, addr: addr, data: data};
        @(negedge clock);
        while (!load_ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (!load_ready) begin
            $display("Loader never accepted the write to 0x%04h", addr);
            test_errors++;
        end
    endtask

    task automatic read_check(byte_addr_t addr, word_t expected, logic stalls);
        int    cycles;
        logic  taken;
        logic  seen;
        logic  done;
        word_t held;
        cycles = 0;
        seen   = 1'b0;
        done   = 1'b0;
        held   = '0;
        @(posedge clock);
        read_valid <= 1'b1;
        read_addr  <= addr;
        @(negedge clock);
        while (!read_ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        taken = read_ready;
        @(posedge clock);
        read_valid <= 1'b0;  // Request transfers on this edge
        if (!taken) begin
            $display("Read request for 0x%04h was never accepted", addr);
            test_errors++;
            return;
        end
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            resp_ready <= stalls ? ($urandom % 2 == 0) : 1'b1;
            @(negedge clock);
            cycles++;
            if (resp_valid) begin
                if (seen && resp_data !== held) begin
                    $display("Fail at %0d ns: resp_data under stall expected 0x%08h got 0x%08h",
                             $time, held, resp_data);
                    test_errors++;
                end
                held = resp_data;
                seen = 1'b1;
                done = resp_ready;
            end
            @(posedge clock);
        end
        resp_ready <= 1'b0;
        if (!done) begin
            $display("No response arrived for the read of 0x%04h", addr);
            test_errors++;
            return;
        end
        if (held !== expected) begin
            $display("Fail at %0d ns: resp_data at 0x%04h expected 0x%08h got 0x%08h",
                     $time, addr, expected, held);
            test_errors++;
        end
        @(negedge clock);
        if (resp_valid) begin
            $display("A second response followed the read of 0x%04h", addr);
            test_errors++;
        end
    endtask

    task automatic wait_halted(logic level, output logic reached);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (halted !== level && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        reached = (halted === level);
    endtask

    initial begin
        logic reached;
        void'($urandom(38897));
        reset_n    = 1'b0;
        run        = 1'b0;
        load_valid = 1'b0;
        load_req   = '0;
        read_valid = 1'b0;
        read_addr  = '0;
        resp_ready = 1'b0;
        pass_count = 0;
        fail_count = 0;
        build_table();
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        if (halted !== 1'b0) begin
            $display("Fail at %0d ns: halted expected 0 got %b", $time, halted);
            fail_count++;
        end
        if (resp_valid !== 1'b0) begin
            $display("Fail at %0d ns: resp_valid expected 0 got %b", $time, resp_valid);
            fail_count++;
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            for (int i = 0; i < prog_len[t]; i++) begin
                load_word(1'b0, byte_addr_t'(4 * i), prog[t][i]);
            end
            for (int i = 0; i < data_len[t]; i++) begin
                load_word(1'b1, data_addr[t][i], data_val[t][i]);
            end
            @(posedge clock);
            load_valid <= 1'b0;
            repeat (6) @(posedge clock);  // Last write settles in the RAM
            run <= 1'b1;
            wait_halted(1'b1, reached);
            if (!reached) begin
                $display("Test %0d: the core did not halt within %0d cycles", t, TIMEOUT_CYCLES);
                test_errors++;
            end else begin
                for (int i = 0; i < res_len[t]; i++) begin
                    read_check(res_addr[t][i], res_val[t][i], stall[t]);
                end
            end
            @(posedge clock);
            run <= 1'b0;
            wait_halted(1'b0, reached);
            if (!reached) begin
                $display("Test %0d: halted stayed high after run went low", t);
                test_errors++;
            end
            if (test_errors == 0) begin
                $display("Test %0d passed", t);
                pass_count++;
            end else begin
                $display("Test %0d failed with %0d errors", t, test_errors);
                fail_count++;
            end
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
shader_pkg.sv
block_ram.sv
program_loader.sv
memory_port_select.sv
shader_core.sv
result_reader.sv
shader_subsystem.sv
tb_shader_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_shader_subsystem -f verilog.f -o tb_shader_subsystem
./obj_dir/tb_shader_subsystem | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "Testbench reported failure, see sim.log"
exit 1
